//--- compile.f
+incdir+rtl
+incdir+testbench
rtl/cache_pkg.sv
rtl/way_store.sv
rtl/tag_match.sv
rtl/victim_select.sv
rtl/bank_ctrl.sv
rtl/fiber_bank.sv
testbench/fiber_bank_checker.sv
testbench/tb_fiber_bank.sv

//--- rtl/bank_ctrl.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module bank_ctrl (
    input  logic                     i_clk,
    input  logic                     i_nreset,
    input  logic                     i_type_valid,
    input  cache_pkg::req_kind_e     i_request_type,
    input  cache_pkg::cache_addr_u   i_addr,
    input  logic [`CACHE_DATA_W-1:0] i_data,
    output logic                     o_type_ready,
    input  cache_pkg::set_view_t     i_set_view,
    input  logic [`CACHE_WAYS-1:0]   i_hit_way,
    input  logic                     i_hit,
    input  logic [`CACHE_DATA_W-1:0] i_hit_data,
    input  logic [`CACHE_WAYS-1:0]   i_victim_way,
    input  logic                     i_victim_dirty,
    output logic                     o_rd_en,
    output logic [`CACHE_SET_W-1:0]  o_set,
    output cache_pkg::way_write_t    o_wr,
    output logic [`CACHE_TAG_W-1:0]  o_lookup_tag,
    output logic [`CACHE_DATA_W-1:0] o_pe_data,
    output logic                     o_pe_data_valid,
    input  logic                     i_pe_data_ready,
    output cache_pkg::cache_addr_u   o_dram_addr,
    output logic [`CACHE_DATA_W-1:0] o_dram_wr_data,
    output logic                     o_dram_wr_valid,
    input  logic                     i_dram_wr_ready,
    input  logic [`CACHE_DATA_W-1:0] i_dram_rd_data,
    input  logic                     i_dram_rd_valid,
    output logic                     o_dram_rd_ready
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_RESPOND, ST_WRITEBACK, ST_REFILL
    } state_e;

    localparam way_meta_t MISS_META = '{prio: 1, srrip: 2};

    state_e                   state;
    req_kind_e                kind_q;
    cache_addr_u              addr_q;
    logic [`CACHE_DATA_W-1:0] data_q;
    logic [`CACHE_DATA_W-1:0] pe_data_q;
    logic [`CACHE_WAYS-1:0]   victim_q;
    cache_addr_u              wb_addr_q;
    logic [`CACHE_DATA_W-1:0] wb_data_q;
    cache_addr_u              victim_addr;
    logic [`CACHE_DATA_W-1:0] victim_data;
    logic                     accept;
    logic                     meta_upd;

    assign o_type_ready = (state == ST_IDLE);
    assign accept       = i_type_valid && o_type_ready;
    assign o_rd_en      = accept;
    assign o_set        = i_addr.f.set;
    assign o_lookup_tag = addr_q.f.tag;
    assign meta_upd     = (state == ST_LOOKUP) && (kind_q == REQ_FETCH || kind_q == REQ_READ);

    // --------------------------------------------------
    // request FSM
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            state <= ST_IDLE;
        end else begin
            unique case (state)
                ST_IDLE: if (accept) state <= ST_LOOKUP;
                ST_LOOKUP: begin
                    unique case (kind_q)
                        REQ_FETCH: begin
                            if (i_hit)               state <= ST_IDLE;
                            else if (i_victim_dirty) state <= ST_WRITEBACK;
                            else                     state <= ST_REFILL;
                        end
                        REQ_WRITE: state <= ST_IDLE;
                        default:   state <= ST_RESPOND;
                    endcase
                end
                ST_RESPOND:   if (i_pe_data_ready) state <= ST_IDLE;
                ST_WRITEBACK: if (i_dram_wr_ready) state <= ST_REFILL;
                ST_REFILL:    if (i_dram_rd_valid) state <= ST_IDLE;
                default:      state <= ST_IDLE;
            endcase
        end
    end

    // victim line address and word
    always_comb begin
        victim_addr.raw = '0;
        victim_addr.f.set = addr_q.f.set;
        victim_data = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_victim_way[w]) begin
                victim_addr.f.tag = i_set_view.tag[w];
                victim_data       = i_set_view.data[w];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            kind_q <= i_request_type;
            addr_q <= i_addr;
            data_q <= i_data;
        end
        if (state == ST_LOOKUP) begin
            pe_data_q <= i_hit_data;
            victim_q  <= i_victim_way;
            wb_addr_q <= victim_addr;
            wb_data_q <= victim_data;
        end
    end

    // --------------------------------------------------
    // storage updates
    // --------------------------------------------------
    always_comb begin
        o_wr = '0;
        if (state == ST_LOOKUP && kind_q == REQ_WRITE) begin
            o_wr.way      = i_hit_way;
            o_wr.data_en  = 1'b1;
            o_wr.dirty_en = 1'b1;
            o_wr.data     = data_q;
            o_wr.dirty    = 1'b1;
        end else if (state == ST_LOOKUP && kind_q == REQ_CONSUME) begin
            o_wr.way      = i_hit_way;
            o_wr.valid_en = 1'b1;
        end else if (state == ST_REFILL && i_dram_rd_valid) begin
            // new line arrives clean
            o_wr.way      = victim_q;
            o_wr.tag_en   = 1'b1;
            o_wr.data_en  = 1'b1;
            o_wr.valid_en = 1'b1;
            o_wr.dirty_en = 1'b1;
            o_wr.tag      = addr_q.f.tag;
            o_wr.data     = i_dram_rd_data;
            o_wr.valid    = 1'b1;
        end

        for (int w = 0; w < `CACHE_WAYS; w++) begin
            o_wr.meta_en[w] = meta_upd;
            o_wr.meta[w]    = i_set_view.meta[w];
            if (i_hit_way[w]) begin
                o_wr.meta[w].srrip = '0;
                if (kind_q == REQ_FETCH && i_set_view.meta[w].prio != '1)
                    o_wr.meta[w].prio = i_set_view.meta[w].prio + 1'b1;
                else if (kind_q == REQ_READ && i_set_view.meta[w].prio != '0)
                    o_wr.meta[w].prio = i_set_view.meta[w].prio - 1'b1;
            end else if (!i_hit && i_victim_way[w]) begin
                o_wr.meta[w] = MISS_META;
            end else if (i_set_view.meta[w].srrip != '1) begin
                o_wr.meta[w].srrip = i_set_view.meta[w].srrip + 1'b1;
            end
        end
    end

    assign o_pe_data       = pe_data_q;
    assign o_pe_data_valid = (state == ST_RESPOND);
    assign o_dram_wr_data  = wb_data_q;
    assign o_dram_wr_valid = (state == ST_WRITEBACK);
    assign o_dram_rd_ready = (state == ST_REFILL);

    // refill asks for the line-aligned request address
    assign o_dram_addr.raw = (state == ST_WRITEBACK) ? wb_addr_q.raw :
                             {addr_q.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W],
                              {`CACHE_OFFSET_W{1'b0}}};

endmodule

//--- rtl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// request address and line word
`define CACHE_ADDR_W    16
`define CACHE_DATA_W    16
`define CACHE_OFFSET_W  4

// bank geometry
`define CACHE_SETS      4
`define CACHE_SET_W     2
`define CACHE_WAYS      4
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_SET_W - `CACHE_OFFSET_W)

// replacement fields
`define CACHE_PRIO_W    5
`define CACHE_SRRIP_W   2

`endif

//--- rtl/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        REQ_FETCH   = 2'd0,
        REQ_READ    = 2'd1,
        REQ_WRITE   = 2'd2,
        REQ_CONSUME = 2'd3
    } req_kind_e;

    // address split as seen by the bank
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_SET_W-1:0]    set;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        addr_fields_t             f;
    } cache_addr_u;

    typedef struct packed {
        logic [`CACHE_PRIO_W-1:0]  prio;
        logic [`CACHE_SRRIP_W-1:0] srrip;
    } way_meta_t;

    // one whole set, all ways
    typedef struct packed {
        logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_WAYS-1:0][`CACHE_DATA_W-1:0] data;
        logic [`CACHE_WAYS-1:0]                    valid;
        logic [`CACHE_WAYS-1:0]                    dirty;
        way_meta_t [`CACHE_WAYS-1:0]               meta;
    } set_view_t;

    // one storage update into the latched set
    typedef struct packed {
        logic [`CACHE_WAYS-1:0]   way;
        logic                     tag_en;
        logic                     data_en;
        logic                     valid_en;
        logic                     dirty_en;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_DATA_W-1:0] data;
        logic                     valid;
        logic                     dirty;
        logic [`CACHE_WAYS-1:0]   meta_en;
        way_meta_t [`CACHE_WAYS-1:0] meta;
    } way_write_t;

endpackage

//--- rtl/fiber_bank.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module fiber_bank (
    input  logic                     i_clk,
    input  logic                     i_nreset,
    // PE request
    input  logic                     i_type_valid,
    input  cache_pkg::req_kind_e     i_request_type,
    input  cache_pkg::cache_addr_u   i_addr,
    input  logic [`CACHE_DATA_W-1:0] i_data,
    output logic                     o_type_ready,
    // PE response
    output logic [`CACHE_DATA_W-1:0] o_pe_data,
    output logic                     o_pe_data_valid,
    input  logic                     i_pe_data_ready,
    // DRAM side
    output cache_pkg::cache_addr_u   o_dram_addr,
    output logic [`CACHE_DATA_W-1:0] o_dram_wr_data,
    output logic                     o_dram_wr_valid,
    input  logic                     i_dram_wr_ready,
    input  logic [`CACHE_DATA_W-1:0] i_dram_rd_data,
    input  logic                     i_dram_rd_valid,
    output logic                     o_dram_rd_ready
);
    import cache_pkg::*;

    set_view_t                set_view;
    way_write_t               wr;
    logic                     rd_en;
    logic [`CACHE_SET_W-1:0]  set_idx;
    logic [`CACHE_TAG_W-1:0]  lookup_tag;
    logic [`CACHE_WAYS-1:0]   hit_way;
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] hit_data;
    logic [`CACHE_WAYS-1:0]   victim_way;
    logic                     victim_dirty;

    way_store u_store (
        .i_clk(i_clk), .i_nreset(i_nreset), .i_rd_en(rd_en), .i_set(set_idx),
        .i_wr(wr), .o_set_view(set_view)
    );

    // hit check and victim choice on the same set
    tag_match u_match (
        .i_tag(lookup_tag), .i_set_view(set_view), .o_hit_way(hit_way),
        .o_hit(hit), .o_hit_data(hit_data)
    );

    victim_select u_victim (
        .i_set_view(set_view), .o_victim_way(victim_way), .o_victim_dirty(victim_dirty)
    );

    bank_ctrl u_ctrl (
        .i_clk(i_clk), .i_nreset(i_nreset),
        .i_type_valid(i_type_valid), .i_request_type(i_request_type),
        .i_addr(i_addr), .i_data(i_data), .o_type_ready(o_type_ready),
        .i_set_view(set_view),
        .i_hit_way(hit_way), .i_hit(hit), .i_hit_data(hit_data),
        .i_victim_way(victim_way), .i_victim_dirty(victim_dirty),
        .o_rd_en(rd_en), .o_set(set_idx), .o_wr(wr), .o_lookup_tag(lookup_tag),
        .o_pe_data(o_pe_data), .o_pe_data_valid(o_pe_data_valid),
        .i_pe_data_ready(i_pe_data_ready),
        .o_dram_addr(o_dram_addr), .o_dram_wr_data(o_dram_wr_data),
        .o_dram_wr_valid(o_dram_wr_valid), .i_dram_wr_ready(i_dram_wr_ready),
        .i_dram_rd_data(i_dram_rd_data), .i_dram_rd_valid(i_dram_rd_valid),
        .o_dram_rd_ready(o_dram_rd_ready)
    );

endmodule

//--- rtl/tag_match.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module tag_match (
    input  logic [`CACHE_TAG_W-1:0]  i_tag,
    input  cache_pkg::set_view_t     i_set_view,
    output logic [`CACHE_WAYS-1:0]   o_hit_way,
    output logic                     o_hit,
    output logic [`CACHE_DATA_W-1:0] o_hit_data
);

    logic [`CACHE_WAYS-1:0]   match;
    logic [`CACHE_DATA_W-1:0] data_or;

    // a way hits only when valid
    always_comb begin
        data_or = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = i_set_view.valid[w] && (i_set_view.tag[w] == i_tag);
            // at most one way matches, so OR is a mux
            data_or  = data_or | (i_set_view.data[w] & {`CACHE_DATA_W{match[w]}});
        end
    end

    assign o_hit_way  = match;
    assign o_hit      = |match;
    assign o_hit_data = data_or;

endmodule

//--- rtl/victim_select.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module victim_select (
    input  cache_pkg::set_view_t   i_set_view,
    output logic [`CACHE_WAYS-1:0] o_victim_way,
    output logic                   o_victim_dirty
);

    logic [`CACHE_WAYS-1:0]    invalid;
    logic [`CACHE_WAYS-1:0]    cand;
    logic [`CACHE_PRIO_W-1:0]  min_prio;
    logic [`CACHE_SRRIP_W-1:0] max_srrip;
    logic                      found;

    // --------------------------------------------------
    // lowest priority, then highest srrip among those
    // --------------------------------------------------
    always_comb begin
        min_prio = '1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_set_view.meta[w].prio < min_prio) begin
                min_prio = i_set_view.meta[w].prio;
            end
        end

        max_srrip = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_set_view.meta[w].prio == min_prio &&
                i_set_view.meta[w].srrip > max_srrip) begin
                max_srrip = i_set_view.meta[w].srrip;
            end
        end

        for (int w = 0; w < `CACHE_WAYS; w++) begin
            cand[w] = (i_set_view.meta[w].prio == min_prio) &&
                      (i_set_view.meta[w].srrip == max_srrip);
        end
    end

    assign invalid = ~i_set_view.valid;

    // free way wins, lowest index first
    always_comb begin
        o_victim_way = '0;
        found        = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && ((|invalid) ? invalid[w] : cand[w])) begin
                o_victim_way[w] = 1'b1;
                found           = 1'b1;
            end
        end
    end

    assign o_victim_dirty = |(o_victim_way & i_set_view.valid & i_set_view.dirty);

endmodule

//--- rtl/way_store.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module way_store (
    input  logic                    i_clk,
    input  logic                    i_nreset,
    input  logic                    i_rd_en,
    input  logic [`CACHE_SET_W-1:0] i_set,
    input  cache_pkg::way_write_t   i_wr,
    output cache_pkg::set_view_t    o_set_view
);
    import cache_pkg::*;

    logic [`CACHE_TAG_W-1:0]  tag_mem   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_DATA_W-1:0] data_mem  [`CACHE_SETS][`CACHE_WAYS];
    logic                     dirty_mem [`CACHE_SETS][`CACHE_WAYS];
    way_meta_t                meta_mem  [`CACHE_SETS][`CACHE_WAYS];

    // valid bits as one register array
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;

    // set of the request in flight
    logic [`CACHE_SET_W-1:0] set_q;

    always_ff @(posedge i_clk) begin
        if (!i_nreset) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (i_wr.way[w] && i_wr.valid_en) begin
                    valid_q[set_q][w] <= i_wr.valid;
                end
            end
        end
    end

    // --------------------------------------------------
    // whole-set read and per-way writes
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            set_q            <= i_set;
            o_set_view.valid <= valid_q[i_set];
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                o_set_view.tag[w]   <= tag_mem[i_set][w];
                o_set_view.data[w]  <= data_mem[i_set][w];
                o_set_view.dirty[w] <= dirty_mem[i_set][w];
                o_set_view.meta[w]  <= meta_mem[i_set][w];
            end
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (i_wr.way[w] && i_wr.tag_en)   tag_mem[set_q][w]   <= i_wr.tag;
            if (i_wr.way[w] && i_wr.data_en)  data_mem[set_q][w]  <= i_wr.data;
            if (i_wr.way[w] && i_wr.dirty_en) dirty_mem[set_q][w] <= i_wr.dirty;
            // metadata may touch every way at once
            if (i_wr.meta_en[w])              meta_mem[set_q][w]  <= i_wr.meta[w];
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fiber_bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_fiber_bank \
    -o sim_tb_fiber_bank
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_fiber_bank > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- testbench/fiber_bank_checker.sv
`timescale 1ns/1ns

module fiber_bank_checker (
    input logic        i_clk,
    input logic        i_nreset,
    input logic        o_type_ready,
    input logic [15:0] o_pe_data,
    input logic        o_pe_data_valid,
    input logic        i_pe_data_ready,
    input logic [15:0] o_dram_addr,
    input logic [15:0] o_dram_wr_data,
    input logic        o_dram_wr_valid,
    input logic        i_dram_wr_ready,
    input logic        i_dram_rd_valid,
    input logic        o_dram_rd_ready
);

    // held outputs until the transfer
    a_pe_hold: assert property (@(posedge i_clk) disable iff (!i_nreset)
        o_pe_data_valid && !i_pe_data_ready |=> o_pe_data_valid && $stable(o_pe_data))
        else $error("PE response changed before it was taken");

    a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_nreset)
        o_dram_wr_valid && !i_dram_wr_ready |=>
        o_dram_wr_valid && $stable(o_dram_wr_data) && $stable(o_dram_addr))
        else $error("writeback changed before it was taken");

    a_rd_hold: assert property (@(posedge i_clk) disable iff (!i_nreset)
        o_dram_rd_ready && !i_dram_rd_valid |=> o_dram_rd_ready && $stable(o_dram_addr))
        else $error("refill request dropped before data arrived");

    a_busy: assert property (@(posedge i_clk) disable iff (!i_nreset)
        (o_pe_data_valid || o_dram_wr_valid || o_dram_rd_ready) |-> !o_type_ready)
        else $error("bank ready while a transfer is pending");

    a_excl: assert property (@(posedge i_clk) disable iff (!i_nreset)
        !(o_dram_wr_valid && o_dram_rd_ready))
        else $error("writeback and refill active together");

endmodule

bind fiber_bank fiber_bank_checker u_checker (
    .i_clk(i_clk), .i_nreset(i_nreset), .o_type_ready(o_type_ready),
    .o_pe_data(o_pe_data), .o_pe_data_valid(o_pe_data_valid),
    .i_pe_data_ready(i_pe_data_ready), .o_dram_addr(o_dram_addr),
    .o_dram_wr_data(o_dram_wr_data), .o_dram_wr_valid(o_dram_wr_valid),
    .i_dram_wr_ready(i_dram_wr_ready), .i_dram_rd_valid(i_dram_rd_valid),
    .o_dram_rd_ready(o_dram_rd_ready)
);

//--- testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one compare task per kind of result
task automatic check_data(input string name, input logic [`CACHE_DATA_W-1:0] got,
                          input logic [`CACHE_DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s got %h, expected %h", $time, name, got, exp);
        fail_run("data word mismatch");
    end
endtask

task automatic check_addr(input string name, input cache_addr_u got, input cache_addr_u exp);
    if (got.raw !== exp.raw) begin
        $display("[ERROR] %0t ns: %s got %h, expected %h", $time, name, got.raw, exp.raw);
        fail_run("address mismatch");
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s got %b, expected %b", $time, name, got, exp);
        fail_run("flag mismatch");
    end
endtask

// --------------------------------------------------
// reference model of the bank contents
// --------------------------------------------------
logic [`CACHE_TAG_W-1:0]  m_tag   [`CACHE_SETS][`CACHE_WAYS];
logic [`CACHE_DATA_W-1:0] m_data  [`CACHE_SETS][`CACHE_WAYS];
bit                       m_valid [`CACHE_SETS][`CACHE_WAYS];
bit                       m_dirty [`CACHE_SETS][`CACHE_WAYS];
int                       m_prio  [`CACHE_SETS][`CACHE_WAYS];
int                       m_srrip [`CACHE_SETS][`CACHE_WAYS];

function automatic int find_hit(input int s, input logic [`CACHE_TAG_W-1:0] t);
    for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == t) return w;
    end
    return -1;
endfunction

// free way first, then lowest priority, then highest srrip
function automatic int pick_victim(input int s);
    int best;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (!m_valid[s][w]) return w;
    end
    best = 0;
    for (int w = 1; w < `CACHE_WAYS; w++) begin
        if (m_prio[s][w] < m_prio[s][best] ||
            (m_prio[s][w] == m_prio[s][best] && m_srrip[s][w] > m_srrip[s][best]))
            best = w;
    end
    return best;
endfunction

task automatic model_step(input req_kind_e k, input cache_addr_u a,
                          input logic [`CACHE_DATA_W-1:0] wd,
                          output logic [`CACHE_DATA_W-1:0] exp_pe, output logic exp_wb,
                          output cache_addr_u wb_addr,
                          output logic [`CACHE_DATA_W-1:0] wb_data,
                          output logic exp_refill);
    int s;
    int h;
    int v;
    s = a.f.set;
    h = find_hit(s, a.f.tag);
    v = pick_victim(s);
    exp_pe = '0;
    exp_wb = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    exp_refill = 1'b0;
    if (k == REQ_FETCH || k == REQ_READ) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (w == h) begin
                m_srrip[s][w] = 0;
                if (k == REQ_FETCH && m_prio[s][w] < 31) m_prio[s][w]++;
                if (k == REQ_READ && m_prio[s][w] > 0) m_prio[s][w]--;
            end else if (h < 0 && w == v) begin
                m_prio[s][w] = 1;
                m_srrip[s][w] = 2;
            end else if (m_srrip[s][w] < 3) begin
                m_srrip[s][w]++;
            end
        end
    end
    case (k)
        REQ_FETCH: if (h < 0) begin
            exp_wb = m_valid[s][v] && m_dirty[s][v];
            wb_addr.f.tag = m_tag[s][v];
            wb_addr.f.set = a.f.set;
            wb_data = m_data[s][v];
            exp_refill = 1'b1;
            m_tag[s][v] = a.f.tag;
            m_data[s][v] = {a.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], 4'h0} ^ DRAM_XOR;
            m_valid[s][v] = 1'b1;
            m_dirty[s][v] = 1'b0;
        end
        REQ_READ: if (h >= 0) exp_pe = m_data[s][h];
        REQ_WRITE: if (h >= 0) begin
            m_data[s][h] = wd;
            m_dirty[s][h] = 1'b1;
        end
        default: if (h >= 0) begin
            exp_pe = m_data[s][h];
            m_valid[s][h] = 1'b0;
        end
    endcase
endtask

`endif

//--- testbench/tb_fiber_bank.sv
`timescale 1ns/1ns
`include "cache_defs.svh"

module tb_fiber_bank;
    import cache_pkg::*;

    localparam logic [`CACHE_DATA_W-1:0] DRAM_XOR = 16'h5a5a;
    localparam int N_ENTRIES = 21;
    localparam int CYCLE_LIMIT = N_ENTRIES * 20;

    typedef struct {
        req_kind_e                kind;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [`CACHE_DATA_W-1:0] exp_data;
        logic                     exp_wb;
    } entry_t;

    logic                     i_clk = 1'b0;
    logic                     i_nreset;
    logic                     i_type_valid;
    req_kind_e                i_request_type;
    cache_addr_u              i_addr;
    logic [`CACHE_DATA_W-1:0] i_data;
    logic                     o_type_ready;
    logic [`CACHE_DATA_W-1:0] o_pe_data;
    logic                     o_pe_data_valid;
    logic                     i_pe_data_ready;
    cache_addr_u              o_dram_addr;
    logic [`CACHE_DATA_W-1:0] o_dram_wr_data;
    logic                     o_dram_wr_valid;
    logic                     i_dram_wr_ready;
    logic [`CACHE_DATA_W-1:0] i_dram_rd_data;
    logic                     i_dram_rd_valid;
    logic                     o_dram_rd_ready;

    entry_t                   tbl [N_ENTRIES];
    logic [`CACHE_DATA_W-1:0] pe_q [$];
    cache_addr_u              wb_addr_q [$];
    logic [`CACHE_DATA_W-1:0] wb_data_q [$];
    cache_addr_u              refill_q [$];
    int                       seed = 32'h542c1f5d;
    int                       cycles = 0;
    bit                       rd_armed = 1'b0;
    int                       rd_wait = 0;

    fiber_bank DUT (.*);

    always #10 i_clk = ~i_clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    `include "tb_tasks.svh"

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) fail_run("timeout, the bank stopped responding");
    end

    // --------------------------------------------------
    // PE and DRAM responders on the falling edge
    // --------------------------------------------------
    always @(negedge i_clk) begin
        if (i_nreset) begin
            i_pe_data_ready = ($random(seed) & 3) != 0;
            if (o_pe_data_valid && i_pe_data_ready) pe_q.push_back(o_pe_data);
            i_dram_wr_ready = ($random(seed) & 3) != 0;
            if (o_dram_wr_valid && i_dram_wr_ready) begin
                wb_addr_q.push_back(o_dram_addr);
                wb_data_q.push_back(o_dram_wr_data);
            end
            i_dram_rd_valid = 1'b0;
            if (o_dram_rd_ready) begin
                if (!rd_armed) begin
                    rd_armed = 1'b1;
                    rd_wait = $random(seed) & 3;
                end
                if (rd_wait == 0) begin
                    i_dram_rd_valid = 1'b1;
                    i_dram_rd_data = o_dram_addr.raw ^ DRAM_XOR;
                    refill_q.push_back(o_dram_addr);
                    rd_armed = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
        end
    end

    initial begin
        entry_t                   e;
        logic [`CACHE_DATA_W-1:0] m_pe;
        logic                     m_wb;
        cache_addr_u              m_wb_addr;
        logic [`CACHE_DATA_W-1:0] m_wb_data;
        logic                     m_refill;
        cache_addr_u              line;
        int                       n_pe;

        i_nreset = 1'b0;
        i_type_valid = 1'b0;
        i_request_type = REQ_FETCH;
        i_addr = '0;
        i_data = '0;
        i_pe_data_ready = 1'b0;
        i_dram_wr_ready = 1'b0;
        i_dram_rd_data = '0;
        i_dram_rd_valid = 1'b0;

        // one set filled past its ways, then consume and refill
        tbl[0]  = '{REQ_READ,    16'h0040, 16'h0000, 16'h0000, 1'b0};
        tbl[1]  = '{REQ_FETCH,   16'h0040, 16'h0000, 16'h0000, 1'b0};
        tbl[2]  = '{REQ_READ,    16'h0040, 16'h0000, 16'h5a1a, 1'b0};
        tbl[3]  = '{REQ_WRITE,   16'h0040, 16'h1234, 16'h0000, 1'b0};
        tbl[4]  = '{REQ_READ,    16'h0040, 16'h0000, 16'h1234, 1'b0};
        tbl[5]  = '{REQ_WRITE,   16'h0080, 16'hbeef, 16'h0000, 1'b0};
        tbl[6]  = '{REQ_READ,    16'h0080, 16'h0000, 16'h0000, 1'b0};
        tbl[7]  = '{REQ_FETCH,   16'h0080, 16'h0000, 16'h0000, 1'b0};
        tbl[8]  = '{REQ_FETCH,   16'h00c0, 16'h0000, 16'h0000, 1'b0};
        tbl[9]  = '{REQ_FETCH,   16'h0100, 16'h0000, 16'h0000, 1'b0};
        tbl[10] = '{REQ_FETCH,   16'h0140, 16'h0000, 16'h0000, 1'b1};
        tbl[11] = '{REQ_READ,    16'h0040, 16'h0000, 16'h0000, 1'b0};
        tbl[12] = '{REQ_FETCH,   16'h01c0, 16'h0000, 16'h0000, 1'b0};
        // clean victim of the fetch above
        tbl[13] = '{REQ_READ,    16'h0140, 16'h0000, 16'h0000, 1'b0};
        tbl[14] = '{REQ_CONSUME, 16'h00c0, 16'h0000, 16'h5a9a, 1'b0};
        tbl[15] = '{REQ_READ,    16'h00c0, 16'h0000, 16'h0000, 1'b0};
        tbl[16] = '{REQ_FETCH,   16'h0200, 16'h0000, 16'h0000, 1'b0};
        tbl[17] = '{REQ_READ,    16'h0200, 16'h0000, 16'h585a, 1'b0};
        tbl[18] = '{REQ_FETCH,   16'h0010, 16'h0000, 16'h0000, 1'b0};
        tbl[19] = '{REQ_READ,    16'h0013, 16'h0000, 16'h5a4a, 1'b0};
        tbl[20] = '{REQ_READ,    16'h0050, 16'h0000, 16'h0000, 1'b0};

        repeat (2) @(negedge i_clk);
        i_nreset = 1'b1;
        @(negedge i_clk);
        check_flag("o_type_ready", o_type_ready, 1'b1);
        check_flag("o_pe_data_valid", o_pe_data_valid, 1'b0);
        check_flag("o_dram_wr_valid", o_dram_wr_valid, 1'b0);
        check_flag("o_dram_rd_ready", o_dram_rd_ready, 1'b0);

        for (int i = 0; i < N_ENTRIES; i++) begin
            e = tbl[i];
            i_addr.raw = e.addr;
            model_step(e.kind, i_addr, e.wdata, m_pe, m_wb, m_wb_addr, m_wb_data, m_refill);
            check_data("model pe data", m_pe, e.exp_data);
            check_flag("model writeback", m_wb, e.exp_wb);
            pe_q.delete();
            wb_addr_q.delete();
            wb_data_q.delete();
            refill_q.delete();

            i_type_valid = 1'b1;
            i_request_type = e.kind;
            i_data = e.wdata;
            while (!o_type_ready) @(negedge i_clk);
            @(negedge i_clk);
            i_type_valid = 1'b0;
            while (!o_type_ready) @(negedge i_clk);

            n_pe = (e.kind == REQ_READ || e.kind == REQ_CONSUME) ? 1 : 0;
            if (pe_q.size() != n_pe) fail_run("wrong number of PE responses");
            if (n_pe == 1) check_data("o_pe_data", pe_q[0], e.exp_data);
            check_flag("writeback seen", wb_addr_q.size() != 0, e.exp_wb);
            if (wb_addr_q.size() > 1) fail_run("more than one writeback for a request");
            if (e.exp_wb) begin
                check_addr("o_dram_addr", wb_addr_q[0], m_wb_addr);
                check_data("o_dram_wr_data", wb_data_q[0], m_wb_data);
            end
            check_flag("refill seen", refill_q.size() != 0, m_refill);
            if (refill_q.size() > 1) fail_run("more than one refill for a request");
            if (m_refill) begin
                line.raw = {e.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], 4'h0};
                check_addr("o_dram_addr", refill_q[0], line);
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
